/* vic_pkg.sv */
`default_nettype none

package vic_pkg;

    // ------------------------------------------------------------------------
    // timing constants
    // ------------------------------------------------------------------------
    // dot4x ticks in one pixel and in one full phi cycle
    localparam int ticks_per_pixel = 4;
    localparam int ticks_per_phi = 32;
    // display window for character dma, in raster lines
    localparam int first_dma_line = 48;
    localparam int last_dma_line = 248;
    // tick within a half phase where the data bus is valid
    localparam int dav_index = 11;
    // phi-high phases that aec holds after ba drops
    localparam int ba_cascade_cycles = 3;
    localparam int x_w = 10;
    localparam int y_w = 9;

    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6567r56a = 2'd1,
        chip_6569     = 2'd2,
        chip_unused   = 2'd3
    } chip_e;

    // only the registers this core still decodes
    typedef enum logic [5:0] {
        reg_ctrl1      = 6'h11,
        reg_raster     = 6'h12,
        reg_irq_status = 6'h19,
        reg_irq_enable = 6'h1a
    } reg_addr_e;

    typedef struct packed {
        logic [x_w-1:0] raster_x_max;
        logic [y_w-1:0] raster_y_max;
        logic [x_w-1:0] chars_ba_start;
        logic [x_w-1:0] chars_ba_end;
    } chip_limits_t;

    // strobes within a half phase, plus the phi level itself
    typedef struct packed {
        logic phi;
        logic pps_start;
        logic pps_badline;
        logic pps_irq;
        logic pps_dav;
        logic pps_end;
        logic dot_first;
        logic dot_last;
    } phase_t;

    // $d011 layout, msb first
    typedef struct packed {
        logic       rc8;
        logic       ecm;
        logic       bmm;
        logic       den;
        logic       rsel;
        logic [2:0] yscroll;
    } ctrl_t;

    function automatic chip_limits_t chip_limits_f(input chip_e chip);
        chip_limits_t lim;
        case (chip)
            // 520 pixels by 263 lines
            chip_6567r8:   lim = '{10'd519, 9'd262, 10'h1f4, 10'h14c};
            // 512 pixels by 262 lines
            chip_6567r56a: lim = '{10'd511, 9'd261, 10'h1f4, 10'h14c};
            // pal, 504 pixels by 312 lines; unused code falls back here
            default:       lim = '{10'd503, 9'd311, 10'h1ec, 10'h14c};
        endcase
        return lim;
    endfunction

endpackage

`default_nettype wire

/* vic_phase_gen.sv */
`default_nettype none

module vic_phase_gen (
    input  wire             clk_dot4x,
    input  wire             rst,
    output vic_pkg::phase_t phase_o,
    output logic            clk_phi_o
);

    // phi level pattern, bit 0 is the current level
    logic [vic_pkg::ticks_per_phi-1:0] phi_sr;
    // one-hot position within the current half phase
    logic [vic_pkg::ticks_per_phi/2-1:0] pps_sr;
    // one-hot position within the current pixel
    logic [vic_pkg::ticks_per_pixel-1:0] dot_sr;

    // phi starts low and sits there for a full half phase after reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_sr <= 32'h0001_fffe;
            pps_sr <= 16'h0001;
            dot_sr <= 4'b0001;
        end else begin
            phi_sr <= {phi_sr[vic_pkg::ticks_per_phi-2:0], phi_sr[vic_pkg::ticks_per_phi-1]};
            pps_sr <= {pps_sr[vic_pkg::ticks_per_phi/2-2:0], pps_sr[vic_pkg::ticks_per_phi/2-1]};
            dot_sr <= {dot_sr[vic_pkg::ticks_per_pixel-2:0], dot_sr[vic_pkg::ticks_per_pixel-1]};
        end
    end

    assign clk_phi_o = phi_sr[0];

    // strobe decode
    always_comb begin
        phase_o.phi         = phi_sr[0];
        phase_o.pps_start   = pps_sr[0];
        // cycle_num is settled from here on
        phase_o.pps_badline = pps_sr[1];
        phase_o.pps_irq     = pps_sr[8];
        phase_o.pps_dav     = pps_sr[vic_pkg::dav_index];
        // phi flips on the next tick
        phase_o.pps_end     = pps_sr[vic_pkg::ticks_per_phi/2-1];
        phase_o.dot_first   = dot_sr[0];
        phase_o.dot_last    = dot_sr[vic_pkg::ticks_per_pixel-1];
    end

endmodule

`default_nettype wire

/* vic_raster.sv */
`default_nettype none

module vic_raster (
    input  wire                       clk_dot4x,
    input  wire                       rst,
    input  vic_pkg::chip_e            chip_i,
    input  vic_pkg::phase_t           phase_i,
    output logic [vic_pkg::x_w-1:0]   raster_x_o,
    output logic [vic_pkg::y_w-1:0]   raster_line_o,
    output logic [vic_pkg::y_w-1:0]   raster_line_d_o,
    output logic [vic_pkg::x_w-4:0]   cycle_num_o
);

    vic_pkg::chip_limits_t lim;

    assign lim = vic_pkg::chip_limits_f(chip_i);

    // ------------------------------------------------------------------------
    // pixel and line counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_o    <= '0;
            raster_line_o <= '0;
        end else if (phase_i.dot_last) begin
            if (raster_x_o == lim.raster_x_max) begin
                raster_x_o <= '0;
                // new line at the x wrap
                if (raster_line_o == lim.raster_y_max)
                    raster_line_o <= '0;
                else
                    raster_line_o <= raster_line_o + 1'b1;
            end else begin
                raster_x_o <= raster_x_o + 1'b1;
            end
        end
    end

    // one pixel behind raster_line, used for compare and readback
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            raster_line_d_o <= '0;
        else if (phase_i.dot_last)
            raster_line_d_o <= raster_line_o;
    end

    // 8 pixels per cycle
    assign cycle_num_o = raster_x_o[vic_pkg::x_w-1:3];

endmodule

`default_nettype wire

/* vic_registers.sv */
`default_nettype none

module vic_registers (
    input  wire                     clk_dot4x,
    input  wire                     rst,
    input  vic_pkg::phase_t         phase_i,
    input  wire                     ce_i,
    input  wire                     rw_i,
    input  wire [5:0]               adi_i,
    input  wire [7:0]               dbi_i,
    input  wire [vic_pkg::y_w-1:0]  raster_line_d_i,
    input  wire                     irst_i,
    output logic [7:0]              dbo_o,
    output vic_pkg::ctrl_t          ctrl_o,
    output logic [vic_pkg::y_w-1:0] raster_cmp_o,
    output logic                    erst_o,
    output logic                    irst_clr_o
);

    logic                wr_stb;
    logic [7:0]          cmp_lo;
    vic_pkg::reg_addr_e  addr;

    assign addr = vic_pkg::reg_addr_e'(adi_i);

    // cpu write, sampled once in the phi-high phase when the data is valid
    assign wr_stb = !ce_i && !rw_i && phase_i.phi && phase_i.pps_dav;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl_o <= '0;
            cmp_lo <= '0;
            erst_o <= 1'b0;
        end else if (wr_stb) begin
            case (addr)
                // bit 7 doubles as compare bit 8
                vic_pkg::reg_ctrl1:      ctrl_o <= vic_pkg::ctrl_t'(dbi_i);
                vic_pkg::reg_raster:     cmp_lo <= dbi_i;
                vic_pkg::reg_irq_enable: erst_o <= dbi_i[0];
                default: ;
            endcase
        end
    end

    assign raster_cmp_o = {ctrl_o.rc8, cmp_lo};

    // writing a 1 acknowledges the raster interrupt
    assign irst_clr_o = wr_stb && (addr == vic_pkg::reg_irq_status) && dbi_i[0];

    // ------------------------------------------------------------------------
    // read side, combinational while selected
    // ------------------------------------------------------------------------
    always_comb begin
        dbo_o = 8'hff;
        if (!ce_i) begin
            case (addr)
                vic_pkg::reg_ctrl1:
                    dbo_o = {raster_line_d_i[8], ctrl_o.ecm, ctrl_o.bmm, ctrl_o.den,
                             ctrl_o.rsel, ctrl_o.yscroll};
                // live line, not the compare value
                vic_pkg::reg_raster:
                    dbo_o = raster_line_d_i[7:0];
                // unused status bits read high as on the real chip
                vic_pkg::reg_irq_status:
                    dbo_o = {irst_i & erst_o, 3'b111, 3'b000, irst_i};
                vic_pkg::reg_irq_enable:
                    dbo_o = {4'hf, 3'b000, erst_o};
                default:
                    dbo_o = 8'hff;
            endcase
        end
    end

endmodule

`default_nettype wire

/* vic_badline.sv */
`default_nettype none

module vic_badline (
    input  wire                    clk_dot4x,
    input  wire                    rst,
    input  vic_pkg::phase_t        phase_i,
    input  wire [vic_pkg::y_w-1:0] raster_line_i,
    input  wire [vic_pkg::y_w-1:0] raster_line_d_i,
    input  wire [vic_pkg::x_w-4:0] cycle_num_i,
    input  vic_pkg::ctrl_t         ctrl_i,
    output logic                   badline_o
);

    logic allow_bad_lines;
    logic allow_nxt;
    logic in_window;

    // den counts anywhere on line 48, its last cycle included.
    // the delayed line still reads 48 there while raster_line has moved on
    always_comb begin
        allow_nxt = allow_bad_lines;
        if (ctrl_i.den && ((raster_line_i == vic_pkg::first_dma_line && cycle_num_i == '0) ||
                raster_line_d_i == vic_pkg::first_dma_line))
            allow_nxt = 1'b1;
        if (raster_line_i == vic_pkg::last_dma_line)
            allow_nxt = 1'b0;
    end

    assign in_window = (raster_line_i >= vic_pkg::first_dma_line) &&
                       (raster_line_i < vic_pkg::last_dma_line);

    // evaluated once per phi cycle, early in the low phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline_o       <= 1'b0;
        end else if (!phase_i.phi && phase_i.pps_badline) begin
            allow_bad_lines <= allow_nxt;
            badline_o       <= allow_nxt && in_window &&
                               (raster_line_i[2:0] == ctrl_i.yscroll);
        end
    end

endmodule

`default_nettype wire

/* vic_bus_arbiter.sv */
`default_nettype none

module vic_bus_arbiter (
    input  wire                    clk_dot4x,
    input  wire                    rst,
    input  vic_pkg::chip_e         chip_i,
    input  vic_pkg::phase_t        phase_i,
    input  wire [vic_pkg::x_w-1:0] raster_x_i,
    input  wire                    badline_i,
    input  wire                    ce_i,
    input  wire                    rw_i,
    output logic                   ba_o,
    output logic                   aec_o,
    output logic                   vic_write_db_o,
    output logic                   vic_write_ab_o
);

    vic_pkg::chip_limits_t lim;
    logic ba_chars;
    // ba history across phi-high phases, msb is the oldest
    logic [vic_pkg::ba_cascade_cycles-1:0] ba_sr;
    logic [1:0] aec_d;

    assign lim = vic_pkg::chip_limits_f(chip_i);

    // ------------------------------------------------------------------------
    // ba for c-accesses
    // ------------------------------------------------------------------------
    // the window wraps through x = 0, hence the or
    assign ba_chars = !(badline_i && (raster_x_i >= lim.chars_ba_start ||
                                      raster_x_i < lim.chars_ba_end));

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o  <= 1'b1;
            ba_sr <= '1;
            aec_o <= 1'b0;
        end else begin
            ba_o <= ba_chars;
            // a low ba walks through the cascade one phi cycle at a time
            if (phase_i.phi && phase_i.pps_end)
                ba_sr <= {ba_sr[vic_pkg::ba_cascade_cycles-2:0], ba_o} |
                         {vic_pkg::ba_cascade_cycles{ba_o}};
            // cpu keeps the bus in phi high until the cascade runs dry
            aec_o <= ba_o ? phase_i.phi : (ba_sr[vic_pkg::ba_cascade_cycles-1] & phase_i.phi);
        end
    end

    // two tick copy of aec for the address driver
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            aec_d <= '0;
        else
            aec_d <= {aec_d[0], aec_o};
    end

    // cpu read of a vic register
    assign vic_write_db_o = rw_i && !ce_i;
    // drive late after aec falls, release as soon as it rises
    assign vic_write_ab_o = !(aec_o | aec_d[1]);

endmodule

`default_nettype wire

/* vic_raster_irq.sv */
`default_nettype none

module vic_raster_irq (
    input  wire                    clk_dot4x,
    input  wire                    rst,
    input  vic_pkg::phase_t        phase_i,
    input  wire [vic_pkg::y_w-1:0] raster_line_d_i,
    input  wire [vic_pkg::y_w-1:0] raster_cmp_i,
    input  wire                    erst_i,
    input  wire                    irst_clr_i,
    output logic                   irst_o,
    output logic                   irq_o
);

    logic [vic_pkg::y_w-1:0] cmp_d;
    // set once the line has fired, dropped when the line no longer matches
    logic triggered;

    // compare value lags a tick so a cpu chasing the line still matches
    always_ff @(posedge clk_dot4x) begin
        cmp_d <= raster_cmp_i;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst_o    <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (raster_line_d_i == cmp_d) begin
                if (!phase_i.phi && phase_i.pps_irq && !triggered) begin
                    triggered <= 1'b1;
                    irst_o    <= 1'b1;
                end
            end else begin
                triggered <= 1'b0;
            end
            // cpu acknowledge wins over a same-tick set
            if (irst_clr_i)
                irst_o <= 1'b0;
        end
    end

    // latch runs regardless of the enable bit
    assign irq_o = irst_o & erst_i;

endmodule

`default_nettype wire

/* vic_top.sv */
`default_nettype none

module vic_top (
    input  wire            clk_dot4x,
    input  wire            rst,
    input  vic_pkg::chip_e chip_i,
    input  wire            ce_i,
    input  wire            rw_i,
    input  wire [5:0]      adi_i,
    input  wire [7:0]      dbi_i,
    output logic [7:0]     dbo_o,
    output logic           clk_phi_o,
    output logic           ba_o,
    output logic           aec_o,
    output logic           irq_o,
    output logic           vic_write_db_o,
    output logic           vic_write_ab_o
);

    vic_pkg::phase_t         phase;
    vic_pkg::ctrl_t          ctrl;
    logic [vic_pkg::x_w-1:0] raster_x;
    logic [vic_pkg::y_w-1:0] raster_line;
    logic [vic_pkg::y_w-1:0] raster_line_d;
    logic [vic_pkg::x_w-4:0] cycle_num;
    logic [vic_pkg::y_w-1:0] raster_cmp;
    logic erst;
    logic irst;
    logic irst_clr;
    logic badline;

    // ------------------------------------------------------------------------
    // execute side, timing and bus
    // ------------------------------------------------------------------------
    vic_phase_gen vic_phase_gen_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase),
        .clk_phi_o (clk_phi_o)
    );

    vic_raster vic_raster_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .chip_i          (chip_i),
        .phase_i         (phase),
        .raster_x_o      (raster_x),
        .raster_line_o   (raster_line),
        .raster_line_d_o (raster_line_d),
        .cycle_num_o     (cycle_num)
    );

    vic_badline vic_badline_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .raster_line_i   (raster_line),
        .raster_line_d_i (raster_line_d),
        .cycle_num_i     (cycle_num),
        .ctrl_i          (ctrl),
        .badline_o       (badline)
    );

    vic_bus_arbiter vic_bus_arbiter_i (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip_i),
        .phase_i        (phase),
        .raster_x_i     (raster_x),
        .badline_i      (badline),
        .ce_i           (ce_i),
        .rw_i           (rw_i),
        .ba_o           (ba_o),
        .aec_o          (aec_o),
        .vic_write_db_o (vic_write_db_o),
        .vic_write_ab_o (vic_write_ab_o)
    );

    // ------------------------------------------------------------------------
    // register file and raster interrupt
    // ------------------------------------------------------------------------
    vic_registers vic_registers_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .ce_i            (ce_i),
        .rw_i            (rw_i),
        .adi_i           (adi_i),
        .dbi_i           (dbi_i),
        .raster_line_d_i (raster_line_d),
        .irst_i          (irst),
        .dbo_o           (dbo_o),
        .ctrl_o          (ctrl),
        .raster_cmp_o    (raster_cmp),
        .erst_o          (erst),
        .irst_clr_o      (irst_clr)
    );

    vic_raster_irq vic_raster_irq_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .raster_line_d_i (raster_line_d),
        .raster_cmp_i    (raster_cmp),
        .erst_i          (erst),
        .irst_clr_i      (irst_clr),
        .irst_o          (irst),
        .irq_o           (irq_o)
    );

endmodule

`default_nettype wire

/* tb_vic_checker.sv */
`default_nettype none

module tb_vic_checker (
    input  wire       clk_dot4x,
    input  wire       rst,
    input  wire       ce_i,
    input  wire       rw_i,
    input  wire       clk_phi_i,
    input  wire       ba_i,
    input  wire       aec_i,
    input  wire       write_db_i,
    input  wire       write_ab_i,
    input  wire [7:0] ctrl_i,
    input  int        x_max_i,
    input  int        y_max_i
);

    longint ticks;
    int     err_count = 0;
    int     test_errs = 0;
    int     tests_ok = 0;
    int     tests_bad = 0;
    int     hi_cnt = 0;
    // aec as seen on the last two ticks
    logic   aec_p1 = 1'b0;
    logic   aec_p2 = 1'b0;

    task automatic report_fail(input string msg);
        err_count++;
        test_errs++;
        $display("%s", msg);
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] t=%0t %s got %0h exp %0h", $time, name, got, exp));
    endtask

    task automatic end_test(input int idx);
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %0d ok", idx);
        end else begin
            tests_bad++;
            $display("test %0d failed with %0d errors", idx, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic print_counts();
        $display("tests passed %0d failed %0d errors %0d", tests_ok, tests_bad, err_count);
    endtask

    // raster line from the tick count at 4 ticks per pixel
    function automatic int line_at(input longint tt);
        return int'(((tt / 4) / (x_max_i + 1)) % (y_max_i + 1));
    endfunction

    // pixel position within the line
    function automatic int x_at(input longint tt);
        return int'((tt / 4) % (x_max_i + 1));
    endfunction

    function automatic bit badline_ok(input int line);
        return ctrl_i[4] && line >= 48 && line < 248 && line[2:0] == ctrl_i[2:0];
    endfunction

    // ticks since reset release
    always @(posedge clk_dot4x) begin
        if (rst)
            ticks <= 0;
        else
            ticks <= ticks + 1;
    end

    // -------------------------------------------------------------------------
    // phi, bus enable, badline and aec monitors
    // -------------------------------------------------------------------------
    always @(negedge clk_dot4x) begin
        if (!rst) begin
            check_value("clk_phi_o", clk_phi_i, (ticks / 16) % 2);
            check_value("vic_write_db_o", write_db_i, rw_i && !ce_i);
            // address driver lets go at once and takes over two ticks late
            check_value("vic_write_ab_o", write_ab_i, !(aec_i || aec_p2));
            aec_p2 = aec_p1;
            aec_p1 = aec_i;
            // ba may trail a line change by a couple of ticks
            if (!ba_i && !badline_ok(line_at(ticks)) &&
                    !(ticks >= 8 && badline_ok(line_at(ticks - 8))))
                report_fail($sformatf("t=%0t ba_o went low on line %0d, which is not a badline",
                                      $time, line_at(ticks)));
            // well inside the character window every badline holds ba low
            if (x_at(ticks) == 160 && ticks % 4 == 0)
                check_value("ba_o", ba_i, !badline_ok(line_at(ticks)));
            if (ticks % 16 == 8) begin
                if ((ticks / 16) % 2 == 1) begin
                    // mid phi-high phase
                    hi_cnt = ba_i ? 0 : hi_cnt + 1;
                    check_value("aec_o", aec_i, hi_cnt <= 3);
                end else begin
                    check_value("aec_o", aec_i, 0);
                end
            end
        end else begin
            hi_cnt = 0;
            aec_p1 = 1'b0;
            aec_p2 = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb_vic.sv */
`default_nettype none

module tb_vic;

    logic           clk_dot4x = 1'b0;
    logic           rst = 1'b1;
    vic_pkg::chip_e chip = vic_pkg::chip_6569;
    logic           ce = 1'b1;
    logic           rw = 1'b1;
    logic [5:0]     adi = '0;
    logic [7:0]     dbi = '0;
    logic [7:0]     dbo;
    logic           clk_phi;
    logic           ba;
    logic           aec;
    logic           irq;
    logic           write_db;
    logic           write_ab;
    // model settings for the checker, changed only under reset
    logic [7:0]     ctrl_cfg = '0;
    int             x_max = 503;
    int             y_max = 311;

    always #10 clk_dot4x = ~clk_dot4x;

    vic_top vic_top_i (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip),
        .ce_i           (ce),
        .rw_i           (rw),
        .adi_i          (adi),
        .dbi_i          (dbi),
        .dbo_o          (dbo),
        .clk_phi_o      (clk_phi),
        .ba_o           (ba),
        .aec_o          (aec),
        .irq_o          (irq),
        .vic_write_db_o (write_db),
        .vic_write_ab_o (write_ab)
    );

    tb_vic_checker checker_i (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .ce_i       (ce),
        .rw_i       (rw),
        .clk_phi_i  (clk_phi),
        .ba_i       (ba),
        .aec_i      (aec),
        .write_db_i (write_db),
        .write_ab_i (write_ab),
        .ctrl_i     (ctrl_cfg),
        .x_max_i    (x_max),
        .y_max_i    (y_max)
    );

    // one full phi cycle holds exactly one write strobe
    task automatic write_register(input logic [5:0] addr, input logic [7:0] data);
        @(posedge clk_dot4x);
        ce <= 1'b0;
        rw <= 1'b0;
        adi <= addr;
        dbi <= data;
        repeat (32) @(posedge clk_dot4x);
        ce <= 1'b1;
        rw <= 1'b1;
    endtask

    task automatic read_register(input logic [5:0] addr, output logic [7:0] data);
        @(posedge clk_dot4x);
        ce <= 1'b0;
        adi <= addr;
        @(negedge clk_dot4x);
        data = dbo;
        @(posedge clk_dot4x);
        ce <= 1'b1;
    endtask

    // irq_o low first and then high, within limit ticks in all
    task automatic wait_irq_rise(input longint limit, output time at, output bit ok);
        longint n;
        n = 1;
        @(negedge clk_dot4x);
        while (irq && n < limit) begin
            @(negedge clk_dot4x);
            n++;
        end
        while (!irq && n < limit) begin
            @(negedge clk_dot4x);
            n++;
        end
        ok = irq && n < limit;
        at = $time;
    endtask

    // one line of the data file, from reset to the second raster interrupt
    task automatic run_test(input int c, input int ctl, input int cmp, input int en,
                            input int rb, input int xm, input int ym, output bit ok);
        logic [7:0] rd;
        longint     frame;
        longint     n;
        time        t1;
        time        t2;
        ok = 1'b1;
        frame = 4 * longint'(xm + 1) * (ym + 1);
        // reset for every chip
        @(posedge clk_dot4x);
        rst <= 1'b1;
        chip <= vic_pkg::chip_e'(c[1:0]);
        ctrl_cfg <= ctl[7:0];
        x_max <= xm;
        y_max <= ym;
        repeat (5) @(posedge clk_dot4x);
        rst <= 1'b0;
        @(negedge clk_dot4x);
        checker_i.check_value("ba_o", ba, 1);
        checker_i.check_value("aec_o", aec, 0);
        checker_i.check_value("irq_o", irq, 0);
        write_register(6'h11, {cmp[8], ctl[6:0]});
        write_register(6'h12, cmp[7:0]);
        // drop the line 0 match left from reset
        write_register(6'h19, 8'h01);
        write_register(6'h1a, en[7:0]);
        read_register(6'h11, rd);
        checker_i.check_value("dbo_o ctrl1", rd, rb);
        read_register(6'h1a, rd);
        checker_i.check_value("dbo_o irq_enable", rd, 8'hf0 | en[0]);
        read_register(6'h3f, rd);
        checker_i.check_value("dbo_o unused", rd, 8'hff);
        wait_irq_rise(2 * frame, t1, ok);
        if (!ok) begin
            checker_i.report_fail($sformatf("t=%0t irq_o never rose for line %0d", $time, cmp));
            return;
        end
        read_register(6'h12, rd);
        checker_i.check_value("dbo_o raster", rd, cmp[7:0]);
        write_register(6'h19, 8'h01);
        @(negedge clk_dot4x);
        checker_i.check_value("irq_o after clear", irq, 0);
        // irq stays low for the rest of the matching line
        @(posedge clk_dot4x);
        ce <= 1'b0;
        adi <= 6'h12;
        n = 0;
        @(negedge clk_dot4x);
        while (dbo == cmp[7:0] && n < 2 * frame) begin
            checker_i.check_value("irq_o same line", irq, 0);
            @(negedge clk_dot4x);
            n++;
        end
        @(posedge clk_dot4x);
        ce <= 1'b1;
        if (n >= 2 * frame) begin
            ok = 1'b0;
            checker_i.report_fail($sformatf("t=%0t raster line %0d never moved on", $time, cmp));
            return;
        end
        wait_irq_rise(2 * frame, t2, ok);
        if (!ok) begin
            checker_i.report_fail($sformatf("t=%0t irq_o did not rise again a frame later",
                                            $time));
            return;
        end
        checker_i.check_value("irq_o frame ticks", (t2 - t1) / 20, frame);
        write_register(6'h19, 8'h01);
    endtask

    initial begin
        int    fd;
        int    idx;
        int    c;
        int    ctl;
        int    cmp;
        int    en;
        int    rb;
        int    xm;
        int    ym;
        bit    ok;
        string s;
        ok = 1'b1;
        idx = 0;
        fd = $fopen("tb_vic_input.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
            $display("could not open tb_vic_input.txt");
        end else begin
            while (ok && $fgets(s, fd)) begin
                if (s.len() >= 2 && s[0] != "#") begin
                    void'($sscanf(s, "%h %h %h %h %h %d %d", c, ctl, cmp, en, rb, xm, ym));
                    run_test(c, ctl, cmp, en, rb, xm, ym, ok);
                    checker_i.end_test(idx);
                    idx++;
                end
            end
            $fclose(fd);
        end
        checker_i.print_counts();
        if (ok && checker_i.err_count == 0 && idx > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
vic_pkg.sv
vic_phase_gen.sv
vic_raster.sv
vic_registers.sv
vic_badline.sv
vic_bus_arbiter.sv
vic_raster_irq.sv
vic_top.sv
tb_vic_checker.sv
tb_vic.sv

/* tb_vic_input.txt */
# chip ctrl1 cmp_line irq_en ctrl1_readback   (hex)   raster_x_max raster_y_max   (decimal)
# ctrl1 bit 7 is driven from cmp_line bit 8 by the testbench
2 1b 030 1 1b 503 311
0 1d 105 1 1d 519 262
1 17 064 1 17 511 261
3 0a 0c8 1 0a 503 311
